/* hw/ex_pkg.sv */
// execute stage shared types
package ex_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and constants
	//////////////////////////////////////////////////////////////////////

	localparam int XLEN      = 64;  // datapath width
	localparam int NUM_LANES = 2;   // two-way issue
	localparam int AR_IDX_W  = 5;   // architectural reg index
	localparam int PR_IDX_W  = 7;   // physical reg index

	localparam logic [AR_IDX_W-1:0] ZERO_REG = 5'd31; // r31 reads as zero

	// poison values, easy to spot in waves
	localparam logic [XLEN-1:0] OPB_POISON = 64'hbaad_beef_dead_beef;
	localparam logic [XLEN-1:0] ALU_POISON = 64'hdead_beef_baad_beef;

	//////////////////////////////////////////////////////////////////////
	// decoder encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		ALU_ADD    = 5'd0,
		ALU_SUB    = 5'd1,
		ALU_AND    = 5'd2,
		ALU_BIC    = 5'd3,  // and with complement
		ALU_BIS    = 5'd4,  // or
		ALU_ORNOT  = 5'd5,
		ALU_XOR    = 5'd6,
		ALU_EQV    = 5'd7,  // xnor
		ALU_SRL    = 5'd8,
		ALU_SLL    = 5'd9,
		ALU_SRA    = 5'd10,
		ALU_CMPULT = 5'd11,
		ALU_CMPEQ  = 5'd12,
		ALU_CMPULE = 5'd13,
		ALU_CMPLT  = 5'd14,
		ALU_CMPLE  = 5'd15
	} alu_func_e;

	typedef enum logic [1:0] {
		OPA_REGA     = 2'd0,
		OPA_MEM_DISP = 2'd1,
		OPA_NPC      = 2'd2,
		OPA_NOT3     = 2'd3  // ~3, aligns jump targets
	} opa_sel_e;

	// code 3 has no meaning here
	typedef enum logic [1:0] {
		OPB_REGB    = 2'd0,
		OPB_ALU_IMM = 2'd1,
		OPB_BR_DISP = 2'd2
	} opb_sel_e;

	//////////////////////////////////////////////////////////////////////
	// issue and completion packets
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [XLEN-1:0]     npc;        // pc + 4
		logic [31:0]         ir;         // raw instruction word
		logic [XLEN-1:0]     rega;       // prf read port a
		logic [XLEN-1:0]     regb;       // prf read port b
		logic [AR_IDX_W-1:0] dest_ar;
		logic [PR_IDX_W-1:0] dest_pr;
		opa_sel_e            opa_sel;
		opb_sel_e            opb_sel;
		alu_func_e           alu_func;
		logic                cond_br;
		logic                uncond_br;
		logic                pred_taken; // fetch prediction
		logic [XLEN-1:0]     pred_addr;
		logic                valid;
	} ex_issue_t;

	typedef struct packed {
		logic                complete;
		logic [AR_IDX_W-1:0] dest_ar;
		logic [PR_IDX_W-1:0] dest_pr;
		logic [XLEN-1:0]     result;       // write-back value
		logic                write_enable;
		logic                exception;    // mispredict, flush needed
		logic [XLEN-1:0]     actual_addr;
		logic                actual_taken;
	} cdb_packet_t;

endpackage

/* hw/operand_decode.sv */
// alu operand decode
module operand_decode
	import ex_pkg::*;
(
	input  logic            clock,   // assertion sampling only
	input  logic [31:0]     ir,
	input  logic [XLEN-1:0] npc,
	input  logic [XLEN-1:0] rega,
	input  logic [XLEN-1:0] regb,
	input  opa_sel_e        opa_sel,
	input  opb_sel_e        opb_sel,
	input  logic            valid,
	output logic [XLEN-1:0] opa,
	output logic [XLEN-1:0] opb
);

	logic [XLEN-1:0] mem_disp;
	logic [XLEN-1:0] br_disp;
	logic [XLEN-1:0] alu_imm;
	logic [XLEN-1:0] not3;

	//////////////////////////////////////////////////////////////////////
	// immediates
	//////////////////////////////////////////////////////////////////////

	// memory format, 16-bit signed displacement
	assign mem_disp = {{(XLEN-16){ir[15]}}, ir[15:0]};

	// branch format, 21-bit signed word offset
	assign br_disp = {{(XLEN-23){ir[20]}}, ir[20:0], 2'b00};

	// operate format literal, unsigned 8 bits
	assign alu_imm = {{(XLEN-8){1'b0}}, ir[20:13]};

	assign not3 = {{(XLEN-2){1'b1}}, 2'b00}; // mask for jmp target

	//////////////////////////////////////////////////////////////////////
	// operand muxes
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (opa_sel)
			OPA_REGA:     opa = rega;
			OPA_MEM_DISP: opa = mem_disp;
			OPA_NPC:      opa = npc;
			default:      opa = not3;  // OPA_NOT3
		endcase
	end

	always_comb
	begin
		case (opb_sel)
			OPB_REGB:    opb = regb;
			OPB_ALU_IMM: opb = alu_imm;
			OPB_BR_DISP: opb = br_disp;
			default:     opb = OPB_POISON; // bad select from decoder
		endcase
	end

	// decoder never issues the spare opb code on a live instruction
	a_opb_sel_legal: assert property (@(posedge clock)
		valid |-> (opb_sel inside {OPB_REGB, OPB_ALU_IMM, OPB_BR_DISP}))
		else $error("operand_decode: illegal opb_sel %0d on valid issue", opb_sel);

endmodule

/* hw/alu.sv */
// 64-bit integer alu
module alu
	import ex_pkg::*;
(
	input  logic [XLEN-1:0] opa,
	input  logic [XLEN-1:0] opb,
	input  alu_func_e       func,
	output logic [XLEN-1:0] result
);

	logic [5:0] shamt;   // shifts only look at six bits
	logic       lt_s;    // signed a < b
	logic       lt_u;    // unsigned a < b
	logic       eq;

	// signed compare from sign bits
	function automatic logic signed_lt(
		input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b
	);
		if (a[XLEN-1] == b[XLEN-1])
			return a < b;      // same sign, unsigned order holds
		else
			return a[XLEN-1];  // negative one is smaller
	endfunction

	assign shamt = opb[5:0];
	assign lt_u  = opa < opb;
	assign eq    = opa == opb;
	assign lt_s  = signed_lt(opa, opb);

	//////////////////////////////////////////////////////////////////////
	// function select
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (func)
			// arithmetic
			ALU_ADD:    result = opa + opb;
			ALU_SUB:    result = opa - opb;

			// logical
			ALU_AND:    result = opa & opb;
			ALU_BIC:    result = opa & ~opb;
			ALU_BIS:    result = opa | opb;
			ALU_ORNOT:  result = opa | ~opb;
			ALU_XOR:    result = opa ^ opb;
			ALU_EQV:    result = opa ^ ~opb;

			// shifts
			ALU_SRL:    result = opa >> shamt;
			ALU_SLL:    result = opa << shamt;
			ALU_SRA:    result = $signed(opa) >>> shamt;  // sign fill

			// compares, 0 or 1 in bit 0
			ALU_CMPULT: result = {{(XLEN-1){1'b0}}, lt_u};
			ALU_CMPEQ:  result = {{(XLEN-1){1'b0}}, eq};
			ALU_CMPULE: result = {{(XLEN-1){1'b0}}, lt_u | eq};
			ALU_CMPLT:  result = {{(XLEN-1){1'b0}}, lt_s};
			ALU_CMPLE:  result = {{(XLEN-1){1'b0}}, lt_s | eq};

			// codes 16..31 not decoded
			default:    result = ALU_POISON;
		endcase
	end

endmodule

/* hw/branch_resolve.sv */
// branch resolution
module branch_resolve
	import ex_pkg::*;
(
	input  logic [XLEN-1:0] rega,       // value under test
	input  logic [2:0]      cond_func,  // ir[28:26]
	input  logic            cond_br,
	input  logic            uncond_br,
	input  logic            pred_taken,
	input  logic [XLEN-1:0] pred_addr,
	input  logic [XLEN-1:0] target,     // alu computed address
	output logic            taken,
	output logic            exception
);

	logic base_cond;  // before inversion
	logic cond;
	logic is_zero;
	logic is_neg;

	assign is_zero = rega == '0;
	assign is_neg  = rega[XLEN-1];

	//////////////////////////////////////////////////////////////////////
	// condition test
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (cond_func[1:0])
			2'b00:   base_cond = ~rega[0];          // lsb clear
			2'b01:   base_cond = is_zero;           // eq zero
			2'b10:   base_cond = is_neg;            // lt zero
			default: base_cond = is_neg | is_zero;  // le zero
		endcase
	end

	assign cond = base_cond ^ cond_func[2];  // bit 28 flips sense

	//////////////////////////////////////////////////////////////////////
	// taken and mispredict
	//////////////////////////////////////////////////////////////////////

	assign taken = uncond_br | (cond_br & cond);

	always_comb
	begin
		exception = 1'b0;
		if (cond_br && (taken != pred_taken))
			exception = 1'b1;  // direction wrong
		if (uncond_br && (target != pred_addr))
			exception = 1'b1;  // jump target wrong
	end

endmodule

/* hw/alu_lane.sv */
// single execute lane
module alu_lane
	import ex_pkg::*;
(
	input  logic        clock,
	input  ex_issue_t   issue,
	output cdb_packet_t next_pkt
);

	logic [XLEN-1:0] opa;
	logic [XLEN-1:0] opb;
	logic [XLEN-1:0] alu_result;
	logic            taken;
	logic            exception;

	operand_decode u_decode (
		.clock   (clock),
		.ir      (issue.ir),
		.npc     (issue.npc),
		.rega    (issue.rega),
		.regb    (issue.regb),
		.opa_sel (issue.opa_sel),
		.opb_sel (issue.opb_sel),
		.valid   (issue.valid),
		.opa     (opa),
		.opb     (opb)
	);

	alu u_alu (
		.opa    (opa),
		.opb    (opb),
		.func   (issue.alu_func),
		.result (alu_result)
	);

	// condition always checks rega
	branch_resolve u_branch (
		.rega       (issue.rega),
		.cond_func  (issue.ir[28:26]),
		.cond_br    (issue.cond_br),
		.uncond_br  (issue.uncond_br),
		.pred_taken (issue.pred_taken),
		.pred_addr  (issue.pred_addr),
		.target     (alu_result),
		.taken      (taken),
		.exception  (exception)
	);

	// packet assembly, all zero on an empty slot
	always_comb
	begin
		next_pkt = '0;
		if (issue.valid)
		begin
			next_pkt.complete     = issue.valid;
			next_pkt.write_enable = issue.valid;
			next_pkt.dest_ar      = issue.dest_ar;
			next_pkt.dest_pr      = issue.dest_pr;
			next_pkt.exception    = exception;
			next_pkt.actual_addr  = alu_result;
			next_pkt.actual_taken = taken;
			if (issue.dest_ar == ZERO_REG)
				next_pkt.result = '0;           // r31 sink
			else if (taken)
				next_pkt.result = issue.npc;    // link value, this lane's npc
			else
				next_pkt.result = alu_result;
		end
	end

endmodule

/* hw/cdb_result_reg.sv */
// completion output register
module cdb_result_reg
	import ex_pkg::*;
(
	input  logic                        clock,
	input  logic                        rst,
	input  cdb_packet_t [NUM_LANES-1:0] next_pkt,
	output cdb_packet_t [NUM_LANES-1:0] cdb
);

	//////////////////////////////////////////////////////////////////////
	// per-lane register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			cdb <= '0;  // no completions out of reset
		end
		else
		begin
			for (int i = 0; i < NUM_LANES; i++)
			begin
				// empty slot broadcasts nothing
				if (next_pkt[i].complete)
					cdb[i] <= next_pkt[i];
				else
					cdb[i] <= '0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus checks
	//////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_chk
		// flush request must ride on a real completion
		a_exc_has_complete: assert property (@(posedge clock) disable iff (rst)
			cdb[g].exception |-> cdb[g].complete)
			else $error("cdb lane %0d: exception without complete", g);

		// prf write and cdb broadcast go together
		a_we_is_complete: assert property (@(posedge clock) disable iff (rst)
			cdb[g].write_enable == cdb[g].complete)
			else $error("cdb lane %0d: write_enable differs from complete", g);
	end

endmodule

/* hw/ex_stage.sv */
// two-lane execute stage
module ex_stage
	import ex_pkg::*;
(
	input  logic                        clock,
	input  logic                        rst,
	input  ex_issue_t   [NUM_LANES-1:0] issue,  // from reservation station
	output cdb_packet_t [NUM_LANES-1:0] cdb     // to cdb and prf
);

	cdb_packet_t [NUM_LANES-1:0] next_pkt;  // unregistered lane outputs

	//////////////////////////////////////////////////////////////////////
	// lanes
	//////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_LANES; g++)
	begin : g_lane
		alu_lane u_lane (
			.clock    (clock),
			.issue    (issue[g]),
			.next_pkt (next_pkt[g])
		);
	end

	// one cycle to the bus
	cdb_result_reg u_result (
		.clock    (clock),
		.rst      (rst),
		.next_pkt (next_pkt),
		.cdb      (cdb)
	);

endmodule

/* tb/ex_stage_tb.sv */
// execute stage testbench
module ex_stage_tb
	import ex_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 8;
	localparam logic [XLEN-1:0] SIGN = {1'b1, {(XLEN-1){1'b0}}};  // bit 63 only

	typedef ex_issue_t [NUM_LANES-1:0] issue_pair_t;

	logic                        clock = 1'b0;
	logic                        rst;
	ex_issue_t   [NUM_LANES-1:0] issue;
	cdb_packet_t [NUM_LANES-1:0] cdb;
	cdb_packet_t                 exp_pkt [NUM_LANES];  // bus contents after next edge
	issue_pair_t                 table_q [$];          // one issue per lane per row
	int seed   = 75;
	int tag    = 0;  // bumps dest tags per issue
	int cycles = 0;
	int limit  = 0;  // known once the table is built

	ex_stage DUT (
		.clock (clock),
		.rst   (rst),
		.issue (issue),
		.cdb   (cdb)
	);

	always #2 clock = ~clock;  // 4 ns period

	// run length guard
	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("RESULT: FAIL");
			$fatal(1, "timeout, the run did not finish within %0d cycles", limit);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus builders
	//////////////////////////////////////////////////////////////////////

	function automatic logic [XLEN-1:0] rnd64();
		return {$random(seed), $random(seed)};
	endfunction

	// valid non-branch op, random regs and npc
	function automatic ex_issue_t alu_op(alu_func_e f, opa_sel_e sa, opb_sel_e sb,
		logic [31:0] ir);
		ex_issue_t s;
		s = '0;
		s.npc       = rnd64() & ~64'd3;  // word aligned
		s.rega      = rnd64();
		s.regb      = rnd64();
		s.pred_addr = rnd64();  // ignored unless a jump
		s.ir        = ir;
		s.opa_sel   = sa;
		s.opb_sel   = sb;
		s.alu_func  = f;
		s.dest_ar   = AR_IDX_W'(tag % 31);  // r31 only where asked for
		s.dest_pr   = PR_IDX_W'(tag);
		s.valid     = 1'b1;
		tag++;
		return s;
	endfunction

	function automatic ex_issue_t rr(alu_func_e f, logic [XLEN-1:0] ra, logic [XLEN-1:0] rb);
		ex_issue_t s;
		s = alu_op(f, OPA_REGA, OPB_REGB, 32'h4000_0400);
		s.rega = ra;
		s.regb = rb;
		return s;
	endfunction

	// conditional branch, target npc + disp*4
	function automatic ex_issue_t cbr(logic [2:0] cond, logic [XLEN-1:0] ra, logic pred);
		ex_issue_t   s;
		logic [20:0] disp;
		disp = 21'($random(seed));
		s = alu_op(ALU_ADD, OPA_NPC, OPB_BR_DISP, {3'b111, cond, 5'd0, disp});
		s.rega       = ra;
		s.dest_ar    = 5'd26;
		s.cond_br    = 1'b1;
		s.pred_taken = pred;
		return s;
	endfunction

	// register jump, target regb with low bits masked
	function automatic ex_issue_t jmp(logic [AR_IDX_W-1:0] dest, logic hit);
		ex_issue_t s;
		s = alu_op(ALU_AND, OPA_NOT3, OPB_REGB, 32'h6b5a_4000);
		s.dest_ar    = dest;
		s.uncond_br  = 1'b1;
		s.pred_taken = 1'b1;
		s.pred_addr  = hit ? {s.regb[XLEN-1:2], 2'b00} : {s.regb[XLEN-1:1], 1'b1};
		return s;
	endfunction

	function automatic ex_issue_t idle(ex_issue_t s);
		ex_issue_t t;
		t = s;
		t.valid = 1'b0;  // other fields left as garbage
		return t;
	endfunction

	task automatic add_pair(ex_issue_t l0, ex_issue_t l1);
		issue_pair_t p;
		p[0] = l0;
		p[1] = l1;
		table_q.push_back(p);
	endtask

	task automatic build_table();
		logic [XLEN-1:0] v;
		ex_issue_t       t;
		v = rnd64();
		// all sixteen alu functions on register operands
		add_pair(rr(ALU_ADD, rnd64(), rnd64()), rr(ALU_SUB, rnd64(), rnd64()));
		add_pair(rr(ALU_AND, rnd64(), rnd64()), rr(ALU_BIC, rnd64(), rnd64()));
		add_pair(rr(ALU_BIS, rnd64(), rnd64()), rr(ALU_ORNOT, rnd64(), rnd64()));
		add_pair(rr(ALU_XOR, rnd64(), rnd64()), rr(ALU_EQV, rnd64(), rnd64()));
		add_pair(rr(ALU_SRL, rnd64(), 64'd32), rr(ALU_SLL, rnd64(), 64'd63));
		add_pair(rr(ALU_SRA, rnd64() | SIGN, 64'hffc0_0000_0000_0028),  // amount 40
			rr(ALU_SRL, rnd64(), 64'd5));
		add_pair(rr(ALU_SRA, rnd64() & ~SIGN, 64'd33), rr(ALU_SLL, rnd64(), 64'd0));
		add_pair(rr(ALU_CMPULT, rnd64(), rnd64()), rr(ALU_CMPEQ, v, v));
		add_pair(rr(ALU_CMPULE, v, v), rr(ALU_CMPLT, rnd64() | SIGN, rnd64() & ~SIGN));
		add_pair(rr(ALU_CMPLE, rnd64() & ~SIGN, rnd64() | SIGN),
			rr(ALU_CMPLT, rnd64() & ~SIGN, rnd64() | SIGN));
		// operand selects, negative displacements too
		add_pair(alu_op(ALU_ADD, OPA_MEM_DISP, OPB_REGB, 32'h2000_8010),
			alu_op(ALU_ADD, OPA_NPC, OPB_ALU_IMM, {11'd0, 8'hff, 13'd0}));
		add_pair(alu_op(ALU_AND, OPA_NOT3, OPB_REGB, 32'h0),
			alu_op(ALU_ADD, OPA_REGA, OPB_BR_DISP, {11'd0, 21'h1f_fff0}));
		add_pair(alu_op(ALU_BIS, OPA_MEM_DISP, OPB_ALU_IMM, 32'h000b_4123),
			alu_op(ALU_SUB, OPA_NPC, OPB_BR_DISP, {11'd0, 21'h00_0123}));
		// eight condition codes, hits and misses
		add_pair(cbr(3'd0, rnd64() & ~64'd1, 1'b1), cbr(3'd1, '0, 1'b0));
		add_pair(cbr(3'd2, rnd64() | SIGN, 1'b1), cbr(3'd3, '0, 1'b1));
		add_pair(cbr(3'd4, rnd64() & ~64'd1, 1'b1), cbr(3'd5, '0, 1'b0));
		add_pair(cbr(3'd6, rnd64() | SIGN, 1'b0), cbr(3'd7, (rnd64() & ~SIGN) | 64'd2, 1'b0));
		add_pair(cbr(3'd3, (rnd64() & ~SIGN) | 64'd2, 1'b1), cbr(3'd7, '0, 1'b1));
		// unconditional, link value and r31 sink
		add_pair(jmp(5'd26, 1'b1), jmp(5'd26, 1'b0));
		t = cbr(3'd0, rnd64(), 1'b1);
		t.cond_br   = 1'b0;  // pc relative call
		t.uncond_br = 1'b1;
		add_pair(t, jmp(ZERO_REG, 1'b1));
		t = cbr(3'd1, '0, 1'b1);
		t.dest_ar = ZERO_REG;
		add_pair(jmp(ZERO_REG, 1'b0), t);
		// one lane empty, then both, then both live
		add_pair(idle(rr(ALU_XOR, rnd64(), rnd64())), rr(ALU_SUB, rnd64(), rnd64()));
		add_pair(cbr(3'd2, rnd64() | SIGN, 1'b0), idle(jmp(5'd26, 1'b1)));
		add_pair(idle(rr(ALU_ADD, rnd64(), rnd64())), idle(cbr(3'd1, '0, 1'b1)));
		add_pair(jmp(5'd26, 1'b1), rr(ALU_CMPLE, v, v));
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model and checks
	//////////////////////////////////////////////////////////////////////

	function automatic cdb_packet_t expect_pkt(ex_issue_t s);
		cdb_packet_t     p;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] r;
		logic [5:0]      sh;
		logic            hold;  // branch condition
		logic            tk;
		p = '0;
		if (!s.valid)
			return p;  // empty slot
		case (s.opa_sel)
			OPA_REGA:     a = s.rega;
			OPA_MEM_DISP: a = XLEN'($signed(s.ir[15:0]));
			OPA_NPC:      a = s.npc;
			default:      a = ~XLEN'(3);
		endcase
		case (s.opb_sel)
			OPB_ALU_IMM: b = XLEN'(s.ir[20:13]);
			OPB_BR_DISP: b = XLEN'($signed(s.ir[20:0])) * XLEN'(4);
			default:     b = s.regb;
		endcase
		sh = b[5:0];
		case (s.alu_func)
			ALU_ADD:    r = a + b;
			ALU_SUB:    r = a - b;
			ALU_AND:    r = a & b;
			ALU_BIC:    r = a & ~b;
			ALU_BIS:    r = a | b;
			ALU_ORNOT:  r = a | ~b;
			ALU_XOR:    r = a ^ b;
			ALU_EQV:    r = ~(a ^ b);
			ALU_SRL:    r = a >> sh;
			ALU_SLL:    r = a << sh;
			ALU_SRA:    r = XLEN'($signed(a) >>> sh);
			ALU_CMPULT: r = XLEN'(a < b);
			ALU_CMPEQ:  r = XLEN'(a == b);
			ALU_CMPULE: r = XLEN'(a <= b);
			ALU_CMPLT:  r = XLEN'($signed(a) < $signed(b));
			default:    r = XLEN'($signed(a) <= $signed(b));  // cmple
		endcase
		case (s.ir[27:26])
			2'd0:    hold = !s.rega[0];
			2'd1:    hold = s.rega == '0;
			2'd2:    hold = $signed(s.rega) < 64'sd0;
			default: hold = $signed(s.rega) <= 64'sd0;
		endcase
		if (s.ir[28])
			hold = !hold;
		tk = s.uncond_br || (s.cond_br && hold);
		p.complete     = 1'b1;
		p.write_enable = 1'b1;
		p.dest_ar      = s.dest_ar;
		p.dest_pr      = s.dest_pr;
		p.actual_addr  = r;
		p.actual_taken = tk;
		p.exception    = (s.cond_br && tk != s.pred_taken) || (s.uncond_br && r != s.pred_addr);
		p.result       = (s.dest_ar == ZERO_REG) ? '0 : (tk ? s.npc : r);
		return p;
	endfunction

	task automatic check_val(string name, logic [XLEN-1:0] act, logic [XLEN-1:0] exp);
		if (act !== exp)
		begin
			$display("Error: %s actual %h expected %h", name, act, exp);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic check_pkt(int lane, cdb_packet_t act, cdb_packet_t exp);
		string f;
		f = $sformatf("cdb[%0d].", lane);
		check_val({f, "complete"}, XLEN'(act.complete), XLEN'(exp.complete));
		check_val({f, "write_enable"}, XLEN'(act.write_enable), XLEN'(exp.write_enable));
		check_val({f, "dest_ar"}, XLEN'(act.dest_ar), XLEN'(exp.dest_ar));
		check_val({f, "dest_pr"}, XLEN'(act.dest_pr), XLEN'(exp.dest_pr));
		check_val({f, "result"}, act.result, exp.result);
		check_val({f, "exception"}, XLEN'(act.exception), XLEN'(exp.exception));
		check_val({f, "actual_addr"}, act.actual_addr, exp.actual_addr);
		check_val({f, "actual_taken"}, XLEN'(act.actual_taken), XLEN'(exp.actual_taken));
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		issue = '0;
		rst   = 1'b1;
		build_table();
		limit = RESET_CYCLES + table_q.size() + 20;
		issue = table_q[0];  // live issue under reset, must not reach the bus
		repeat (RESET_CYCLES) @(posedge clock);
		#1 rst = 1'b0;
		issue = '0;
		for (int l = 0; l < NUM_LANES; l++)
			check_pkt(l, cdb[l], '0);  // cleared by the last reset edge
		// bus stays clear until the first issue
		repeat (2)
		begin
			@(posedge clock);
			#1;
			for (int l = 0; l < NUM_LANES; l++)
				check_pkt(l, cdb[l], '0);
		end
		foreach (table_q[i])
		begin
			issue = table_q[i];  // 1 ns past the edge
			#2;
			// previous row on the bus, this row not sampled yet
			if (i > 0)
			begin
				for (int l = 0; l < NUM_LANES; l++)
					check_pkt(l, cdb[l], exp_pkt[l]);
			end
			for (int l = 0; l < NUM_LANES; l++)
				exp_pkt[l] = expect_pkt(table_q[i][l]);
			@(posedge clock);
			#1;
		end
		issue = '0;
		#2;
		for (int l = 0; l < NUM_LANES; l++)
			check_pkt(l, cdb[l], exp_pkt[l]);  // last row
		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* sources.f */
hw/ex_pkg.sv
hw/operand_decode.sv
hw/alu.sv
hw/branch_resolve.sv
hw/alu_lane.sv
hw/cdb_result_reg.sv
hw/ex_stage.sv
tb/ex_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the execute stage testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module ex_stage_tb \
	-o ex_stage_sim > sim.log 2>&1 &&
	./obj_dir/ex_stage_sim >> sim.log 2>&1 ||
	echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
